// File: common/sram_fifo_config.svh
// ****************************************
// Sizing of the per-channel byte SRAM
// ****************************************
`ifndef SRAM_FIFO_CONFIG_SVH
`define SRAM_FIFO_CONFIG_SVH

// Entries held by each channel
`define SRAM_DEPTH 8

// Address bits for SRAM_DEPTH entries
`define SRAM_AW 3

`define SRAM_DW 8 // One byte per entry

`endif

// File: common/sram_fifo_pkg.sv
// ****************************************
// Types shared by the two-channel buffer
// ****************************************
`include "sram_fifo_config.svh"

package sram_fifo_pkg;

   typedef logic [`SRAM_DW-1:0] data_t; // One stored byte
   typedef logic [`SRAM_AW-1:0] addr_t;
   typedef logic [`SRAM_AW:0]   count_t; // Counts 0 to SRAM_DEPTH
   typedef logic                chan_t;  // 0 is channel A, 1 is channel B

   // Three phases per SRAM access, plus the head presentation state
   typedef enum logic [2:0] {
      idle,
      wr_setup,
      wr_strobe,
      wr_hold,
      rd_setup,
      rd_strobe,
      rd_hold,
      rd_present
   } seq_state_t;

endpackage

// File: common/sram_port_if.sv
// ****************************************
// Sequencer to SRAM connection
// ****************************************
interface sram_port_if;

   sram_fifo_pkg::addr_t addr;
   sram_fifo_pkg::data_t wdata;
   logic                 rd_n;  // Read strobe, active low
   logic                 wr_n;  // Write strobe, active low
   sram_fifo_pkg::data_t rdata; // Registered read data

   modport ctrl (
      output addr,
      output wdata,
      output rd_n,
      output wr_n,
      input  rdata
   );

   modport mem (
      input  addr,
      input  wdata,
      input  rd_n,
      input  wr_n,
      output rdata
   );

endinterface

// File: sram_fifo/sram_array.sv
// ****************************************
// Single-port synchronous byte SRAM
// ****************************************
`include "sram_fifo_config.svh"

module sram_array (
   input logic      clk,
   sram_port_if.mem port
);

   sram_fifo_pkg::data_t cells [`SRAM_DEPTH]; // Contents undefined until written

   // Write on the low write strobe
   always_ff @(posedge clk) begin
      if (!port.wr_n) begin
         cells[port.addr] <= port.wdata;
      end
   end

   // Read data is registered and held between strobes
   always_ff @(posedge clk) begin
      if (!port.rd_n) begin
         port.rdata <= cells[port.addr];
      end
   end

endmodule

// File: sram_fifo/sram_fifo_ctrl.sv
// ****************************************
// One channel of SRAM-backed byte FIFO
// Setup, strobe and hold per SRAM access
// ****************************************
`include "sram_fifo_config.svh"

module sram_fifo_ctrl (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 in_valid,
   input  sram_fifo_pkg::data_t in_data,
   output logic                 in_ready,
   output logic                 head_valid,
   output sram_fifo_pkg::data_t head_data,
   input  logic                 head_ready,
   sram_port_if.ctrl            mem
);

   sram_fifo_pkg::seq_state_t state, state_next;
   sram_fifo_pkg::addr_t      wr_ptr, rd_ptr;
   sram_fifo_pkg::count_t     count;   // Includes the byte held in the head
   sram_fifo_pkg::data_t      wr_buf;
   logic                      running;  // Set on the first edge after reset
   logic                      head_full;
   logic                      write_take;
   logic                      head_take;

   function automatic sram_fifo_pkg::addr_t ptr_inc(input sram_fifo_pkg::addr_t ptr);
      if (ptr == sram_fifo_pkg::addr_t'(`SRAM_DEPTH - 1)) begin
         return '0;
      end
      return ptr + sram_fifo_pkg::addr_t'(1);
   endfunction

   // Writes are taken in idle, and also while a head waits for the merger
   assign in_ready = running
                   && (state == sram_fifo_pkg::idle || state == sram_fifo_pkg::rd_present)
                   && (count < sram_fifo_pkg::count_t'(`SRAM_DEPTH));
   assign head_valid = (state == sram_fifo_pkg::rd_present);
   assign write_take = in_valid && in_ready;
   assign head_take  = head_valid && head_ready;

   always_comb begin
      state_next = state;
      case (state)
         sram_fifo_pkg::idle: begin
            if (write_take) begin
               state_next = sram_fifo_pkg::wr_setup; // Write wins over a read
            end else if (count != '0 && !head_full) begin
               state_next = sram_fifo_pkg::rd_setup;
            end
         end
         sram_fifo_pkg::wr_setup:  state_next = sram_fifo_pkg::wr_strobe;
         sram_fifo_pkg::wr_strobe: state_next = sram_fifo_pkg::wr_hold;
         sram_fifo_pkg::wr_hold: begin
            // Go back to a head still waiting for the merger
            state_next = head_full ? sram_fifo_pkg::rd_present : sram_fifo_pkg::idle;
         end
         sram_fifo_pkg::rd_setup:  state_next = sram_fifo_pkg::rd_strobe;
         sram_fifo_pkg::rd_strobe: state_next = sram_fifo_pkg::rd_hold;
         sram_fifo_pkg::rd_hold:   state_next = sram_fifo_pkg::rd_present;
         sram_fifo_pkg::rd_present: begin
            if (write_take) begin
               state_next = sram_fifo_pkg::wr_setup;
            end else if (head_take) begin
               state_next = sram_fifo_pkg::idle;
            end
         end
         default: state_next = sram_fifo_pkg::idle;
      endcase
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state     <= sram_fifo_pkg::idle;
         running   <= 1'b0;
         head_full <= 1'b0;
      end else begin
         state   <= state_next;
         running <= 1'b1;
         if (state == sram_fifo_pkg::rd_hold) begin
            head_full <= 1'b1;
         end else if (head_take) begin
            head_full <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (state == sram_fifo_pkg::wr_hold) begin
            wr_ptr <= ptr_inc(wr_ptr); // Address stays put through hold
         end
         if (state == sram_fifo_pkg::rd_hold) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         if (state == sram_fifo_pkg::wr_strobe) begin
            count <= count + sram_fifo_pkg::count_t'(1);
         end else if (head_take) begin
            count <= count - sram_fifo_pkg::count_t'(1);
         end
      end
   end

   // Input byte and head byte
   always_ff @(posedge clk) begin
      if (write_take) begin
         wr_buf <= in_data;
      end
      if (state == sram_fifo_pkg::rd_hold) begin
         head_data <= mem.rdata;
      end
   end

   always_comb begin
      case (state)
         sram_fifo_pkg::wr_setup,
         sram_fifo_pkg::wr_strobe,
         sram_fifo_pkg::wr_hold: mem.addr = wr_ptr;
         default:                mem.addr = rd_ptr;
      endcase
   end

   assign mem.wdata = wr_buf;
   assign mem.wr_n  = (state != sram_fifo_pkg::wr_strobe);
   assign mem.rd_n  = (state != sram_fifo_pkg::rd_strobe);

endmodule

// File: src/chan_merge.sv
// ****************************************
// Round-robin merge of two channel heads
// ****************************************
module chan_merge (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 a_valid,
   input  sram_fifo_pkg::data_t a_data,
   output logic                 a_ready,
   input  logic                 b_valid,
   input  sram_fifo_pkg::data_t b_data,
   output logic                 b_ready,
   output logic                 out_valid,
   output sram_fifo_pkg::data_t out_data,
   output sram_fifo_pkg::chan_t out_chan,
   input  logic                 out_ready
);

   sram_fifo_pkg::chan_t last_chan; // Channel served most recently
   logic                 load;
   logic                 pick_b;

   // Output register free now or after this edge
   assign load = !out_valid || out_ready;

   // On a tie the channel not served last goes first
   assign pick_b = b_valid && (!a_valid || last_chan == 1'b0);

   assign a_ready = load && a_valid && !pick_b;
   assign b_ready = load && pick_b;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         out_valid <= 1'b0;
         last_chan <= 1'b0;
      end else if (load) begin
         out_valid <= a_valid || b_valid;
         if (a_valid || b_valid) begin
            last_chan <= pick_b;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load && (a_valid || b_valid)) begin
         out_data <= pick_b ? b_data : a_data;
         out_chan <= pick_b;
      end
   end

endmodule

// File: src/dual_sram_fifo.sv
// ****************************************
// Two SRAM byte channels merged onto
// one tagged output stream
// ****************************************
module dual_sram_fifo (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 a_in_valid,
   input  sram_fifo_pkg::data_t a_in_data,
   output logic                 a_in_ready,
   input  logic                 b_in_valid,
   input  sram_fifo_pkg::data_t b_in_data,
   output logic                 b_in_ready,
   output logic                 out_valid,
   output sram_fifo_pkg::data_t out_data,
   output sram_fifo_pkg::chan_t out_chan,
   input  logic                 out_ready
);

   logic                 a_head_valid;
   logic                 a_head_ready;
   sram_fifo_pkg::data_t a_head_data;
   logic                 b_head_valid;
   logic                 b_head_ready;
   sram_fifo_pkg::data_t b_head_data;

   sram_port_if a_port ();
   sram_port_if b_port ();

   // Channel A
   sram_fifo_ctrl a_ctrl_inst (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (a_in_valid),
      .in_data    (a_in_data),
      .in_ready   (a_in_ready),
      .head_valid (a_head_valid),
      .head_data  (a_head_data),
      .head_ready (a_head_ready),
      .mem        (a_port)
   );

   sram_array a_sram_inst (
      .clk  (clk),
      .port (a_port)
   );

   // Channel B
   sram_fifo_ctrl b_ctrl_inst (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (b_in_valid),
      .in_data    (b_in_data),
      .in_ready   (b_in_ready),
      .head_valid (b_head_valid),
      .head_data  (b_head_data),
      .head_ready (b_head_ready),
      .mem        (b_port)
   );

   sram_array b_sram_inst (
      .clk  (clk),
      .port (b_port)
   );

   chan_merge chan_merge_inst (
      .clk       (clk),
      .rst       (rst),
      .a_valid   (a_head_valid),
      .a_data    (a_head_data),
      .a_ready   (a_head_ready),
      .b_valid   (b_head_valid),
      .b_data    (b_head_data),
      .b_ready   (b_head_ready),
      .out_valid (out_valid),
      .out_data  (out_data),
      .out_chan  (out_chan),
      .out_ready (out_ready)
   );

endmodule

// File: bench/tb_clock.sv
// ****************************************
// Testbench clock, 20 ns period
// ****************************************
module tb_clock (
   output logic clk
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk; // Half period
   end

endmodule

// File: bench/tb_checker.sv
// ****************************************
// Watches the DUT ports, models both
// channels and counts errors
// ****************************************
`include "sram_fifo_config.svh"

module tb_checker (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 a_in_valid,
   input  sram_fifo_pkg::data_t a_in_data,
   input  logic                 a_in_ready,
   input  logic                 b_in_valid,
   input  sram_fifo_pkg::data_t b_in_data,
   input  logic                 b_in_ready,
   input  logic                 out_valid,
   input  sram_fifo_pkg::data_t out_data,
   input  sram_fifo_pkg::chan_t out_chan,
   input  logic                 out_ready,
   output int                   mismatch_count,
   output int                   protocol_count,
   output int                   leftover_count
);
   timeunit 1ns;
   timeprecision 100ps;

   sram_fifo_pkg::data_t a_q[$]; // Bytes accepted on A, not yet output
   sram_fifo_pkg::data_t b_q[$];
   logic                 in_reset = 1'b0;
   logic                 prev_hold = 1'b0; // Output was stalled at the last edge
   sram_fifo_pkg::data_t prev_data;
   sram_fifo_pkg::chan_t prev_chan;
   int                   a_wait = 0; // Edges with in_ready low although room exists
   int                   b_wait = 0;
   int                   a_occ = 0;  // Bytes inside channel A before the edge
   int                   b_occ = 0;
   int                   run_len = 0;
   sram_fifo_pkg::chan_t run_chan = 1'b0;

   initial begin
      mismatch_count = 0;
      protocol_count = 0;
      leftover_count = 0;
   end

   task automatic protocol_error(input string msg);
      protocol_count++;
      $display("ERROR %0t: %s", $time, msg);
   endtask

   // Compare an output byte with the front of its channel model
   task automatic compare_output();
      sram_fifo_pkg::data_t expected;
      if (out_chan == 1'b0 && a_q.size() == 0) begin
         protocol_error("output tagged A with nothing pending on A");
      end else if (out_chan == 1'b1 && b_q.size() == 0) begin
         protocol_error("output tagged B with nothing pending on B");
      end else begin
         expected = (out_chan == 1'b0) ? a_q.pop_front() : b_q.pop_front();
         if (out_data !== expected) begin
            mismatch_count++;
            $display("ERROR %0t: channel %0d output %h, expected %h",
                     $time, out_chan, out_data, expected);
         end
      end
   endtask

   // Count successive outputs of one tag while the other channel waits
   task automatic track_fairness();
      int other_size;
      other_size = (out_chan == 1'b0) ? b_q.size() : a_q.size();
      if (other_size > 0 && run_len > 0 && out_chan == run_chan) begin
         run_len++;
      end else begin
         run_len = 1;
      end
      run_chan = out_chan;
      if (run_len == 3) begin
         protocol_error("same channel served three times in a row");
      end
   endtask

   always @(posedge clk) begin
      if (!rst) begin
         if (out_valid) protocol_error("out_valid high during reset");
         if (a_in_ready) protocol_error("A in_ready high during reset");
         if (b_in_ready) protocol_error("B in_ready high during reset");
         in_reset  = 1'b1;
         prev_hold = 1'b0;
         a_wait    = 0;
         b_wait    = 0;
         run_len   = 0;
      end else begin
         if (in_reset && out_valid) begin
            protocol_error("out_valid high on first edge after reset");
         end
         in_reset = 1'b0;

         if (prev_hold && (!out_valid || out_data !== prev_data || out_chan !== prev_chan)) begin
            protocol_error("output changed while stalled");
         end
         prev_hold = out_valid && !out_ready;
         prev_data = out_data;
         prev_chan = out_chan;

         // A byte in the output register has already left its channel
         a_occ = a_q.size() - ((out_valid && out_chan == 1'b0) ? 1 : 0);
         b_occ = b_q.size() - ((out_valid && out_chan == 1'b1) ? 1 : 0);
         if (a_in_ready && a_occ >= `SRAM_DEPTH) protocol_error("A in_ready high with A full");
         if (b_in_ready && b_occ >= `SRAM_DEPTH) protocol_error("B in_ready high with B full");

         if (a_in_valid || b_in_valid || !out_ready) run_len = 0; // Only a clean drain counts
         if (out_valid && out_ready) begin
            track_fairness();
            compare_output();
         end

         if (a_in_valid && a_in_ready) a_q.push_back(a_in_data);
         if (b_in_valid && b_in_ready) b_q.push_back(b_in_data);

         a_wait = (!a_in_ready && a_occ < `SRAM_DEPTH) ? a_wait + 1 : 0;
         b_wait = (!b_in_ready && b_occ < `SRAM_DEPTH) ? b_wait + 1 : 0;
         if (a_wait == 11) protocol_error("A in_ready stayed low with room free");
         if (b_wait == 11) protocol_error("B in_ready stayed low with room free");
      end
      leftover_count = a_q.size() + b_q.size();
   end

endmodule

// File: bench/tb_dual_sram_fifo.sv
// ****************************************
// Testbench top for the two-channel
// SRAM byte buffer
// ****************************************
module tb_dual_sram_fifo;
   timeunit 1ns;
   timeprecision 100ps;

   logic                 clk;
   logic                 rst;
   logic                 a_in_valid;
   sram_fifo_pkg::data_t a_in_data;
   logic                 a_in_ready;
   logic                 b_in_valid;
   sram_fifo_pkg::data_t b_in_data;
   logic                 b_in_ready;
   logic                 out_valid;
   sram_fifo_pkg::data_t out_data;
   sram_fifo_pkg::chan_t out_chan;
   logic                 out_ready;
   int                   mismatch_count;
   int                   protocol_count;
   int                   leftover_count;
   logic [18:0]          vec_q[$]; // {a_valid, a_data, b_valid, b_data, out_ready}
   logic                 vectors_ready = 1'b0;
   logic                 file_ok;

   tb_clock tb_clock_inst (.clk(clk));

   dual_sram_fifo dual_sram_fifo_inst (
      .clk        (clk),
      .rst        (rst),
      .a_in_valid (a_in_valid),
      .a_in_data  (a_in_data),
      .a_in_ready (a_in_ready),
      .b_in_valid (b_in_valid),
      .b_in_data  (b_in_data),
      .b_in_ready (b_in_ready),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .out_chan   (out_chan),
      .out_ready  (out_ready)
   );

   tb_checker tb_checker_inst (
      .clk (clk), .rst (rst),
      .a_in_valid (a_in_valid), .a_in_data (a_in_data), .a_in_ready (a_in_ready),
      .b_in_valid (b_in_valid), .b_in_data (b_in_data), .b_in_ready (b_in_ready),
      .out_valid (out_valid), .out_data (out_data), .out_chan (out_chan),
      .out_ready (out_ready),
      .mismatch_count (mismatch_count),
      .protocol_count (protocol_count),
      .leftover_count (leftover_count)
   );

   task automatic load_vectors(output logic ok);
      int    fd;
      int    n;
      int    av, ad, bv, bd, orr;
      string line;
      ok = 1'b0;
      fd = $fopen("bench/tb_input.txt", "r");
      if (fd != 0) begin
         ok = 1'b1;
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin // Skip column notes
               n = $sscanf(line, "%h %h %h %h %h", av, ad, bv, bd, orr);
               if (n == 5) vec_q.push_back({av[0], ad[7:0], bv[0], bd[7:0], orr[0]});
            end
         end
         $fclose(fd);
      end
   endtask

   // Called on a falling edge; returns on the falling edge after the vector is done
   task automatic apply_vector(input logic [18:0] vec);
      logic a_pend;
      logic b_pend;
      a_pend     = vec[18];
      b_pend     = vec[9];
      a_in_data  = vec[17:10];
      b_in_data  = vec[8:1];
      out_ready  = vec[0];
      a_in_valid = a_pend;
      b_in_valid = b_pend;
      if (a_pend && a_in_ready) a_pend = 1'b0; // in_ready is settled before the edge
      if (b_pend && b_in_ready) b_pend = 1'b0;
      @(negedge clk);
      while (a_pend || b_pend) begin
         a_in_valid = a_pend;
         b_in_valid = b_pend;
         if (a_pend && a_in_ready) a_pend = 1'b0;
         if (b_pend && b_in_ready) b_pend = 1'b0;
         @(negedge clk);
      end
      a_in_valid = 1'b0;
      b_in_valid = 1'b0;
   endtask

   initial begin
      rst        = 1'b0;
      a_in_valid = 1'b0;
      a_in_data  = '0;
      b_in_valid = 1'b0;
      b_in_data  = '0;
      out_ready  = 1'b0;
      load_vectors(file_ok);
      if (!file_ok) begin
         $display("Could not open the stimulus file bench/tb_input.txt");
         $display("TB FAILED");
         $finish;
      end else begin
         vectors_ready = 1'b1;
         repeat (3) @(posedge clk);
         @(negedge clk);
         rst = 1'b1;
         foreach (vec_q[i]) apply_vector(vec_q[i]);
         out_ready = 1'b1; // Drain whatever is left
         while (leftover_count != 0 || out_valid) @(negedge clk);
         repeat (4) @(negedge clk);
         $display("mismatches %0d, protocol errors %0d, leftover bytes %0d",
                  mismatch_count, protocol_count, leftover_count);
         if (mismatch_count == 0 && protocol_count == 0 && leftover_count == 0) begin
            $display("TB PASSED");
         end else begin
            $display("TB FAILED");
         end
         $finish;
      end
   end

   // Watchdog sized from the number of vectors
   initial begin
      wait (vectors_ready);
      #((vec_q.size() + 200) * 20);
      $display("Simulation timed out before the tests completed");
      $display("TB FAILED");
      $finish;
   end

endmodule

// File: bench/tb_input.txt
# columns: a_valid a_data b_valid b_data out_ready (hex), one vector per line
# a valid byte stays applied until its channel accepts it
1 11 1 21 1
0 00 1 22 1
0 00 1 23 1
0 00 1 24 1
0 00 0 00 1
0 00 0 00 1
0 00 0 00 1
0 00 0 00 1
0 00 0 00 1
1 a0 0 00 0
1 a1 0 00 0
1 a2 0 00 0
1 a3 0 00 0
1 a4 0 00 0
1 a5 0 00 0
1 a6 0 00 0
1 a7 0 00 0
0 00 1 b0 0
0 00 1 b1 0
0 00 1 b2 0
0 00 1 b3 0
0 00 0 00 0
0 00 0 00 0
0 00 0 00 0
0 00 0 00 1
0 00 0 00 0
0 00 0 00 1
0 00 0 00 0
0 00 0 00 0
0 00 0 00 1

// File: all.f
+incdir+common
common/sram_fifo_pkg.sv
common/sram_port_if.sv
sram_fifo/sram_array.sv
sram_fifo/sram_fifo_ctrl.sv
src/chan_merge.sv
src/dual_sram_fifo.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_dual_sram_fifo.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the two-channel buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_dual_sram_fifo -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "TB FAILED" sim.log; then
   echo "Simulation reported failure"
   exit 1
fi

echo "Simulation finished without failure"
